// File: src/pulp_soc_cfg.svh
`ifndef PULP_SOC_CFG_SVH
`define PULP_SOC_CFG_SVH

// host port
`define HOST_IW 8
`define HOST_DW 64

// soc bus
`define BUS_DW 128
`define AXI_AW 32

// remap slots, also the limit on outstanding host accesses
`define ID_TABLE_DEPTH 4

// L2 memory map, banks interleaved on 128-bit words
`define L2_BASE_ADDR 32'h1C00_0000
`define L2_SIZE 65536
`define L2_N_PORTS 2

// in-flight accesses tracked by the bus
`define ORDER_DEPTH 4

`endif

// File: src/pulp_soc_pkg.sv
`include "pulp_soc_cfg.svh"

package pulp_soc_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  typedef enum logic {
    RESP_OKAY   = 1'b0,
    RESP_DECERR = 1'b1
  } resp_e;

  // index into the host ID table
  typedef logic [$clog2(`ID_TABLE_DEPTH)-1:0] slot_t;

  typedef struct packed {
    logic                  valid;
    op_e                   op;
    logic [`HOST_IW-1:0]   id;
    logic [`AXI_AW-1:0]    addr;
    logic [`HOST_DW-1:0]   wdata;
    logic [`HOST_DW/8-1:0] wstrb;
  } host_req_t;

  typedef struct packed {
    logic                valid;
    logic [`HOST_IW-1:0] id;
    logic [`HOST_DW-1:0] rdata;
    resp_e               status;
  } host_resp_t;

  // bus side carries the slot instead of the host ID
  typedef struct packed {
    logic                 valid;
    op_e                  op;
    slot_t                slot;
    logic [`AXI_AW-1:0]   addr;
    logic [`BUS_DW-1:0]   wdata;
    logic [`BUS_DW/8-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic               valid;
    slot_t              slot;
    logic [`BUS_DW-1:0] rdata;
    resp_e              status;
  } bus_resp_t;

endpackage

// File: src/host_id_remap.sv
`include "pulp_soc_cfg.svh"

module host_id_remap (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  pulp_soc_pkg::host_req_t  host_req_i,
  output logic                     host_req_ready_o,
  output pulp_soc_pkg::host_resp_t host_resp_o,
  input  logic                     host_resp_ready_i,

  output pulp_soc_pkg::bus_req_t   bus_req_o,
  input  logic                     bus_req_ready_i,
  input  pulp_soc_pkg::bus_resp_t  bus_resp_i,
  output logic                     bus_resp_ready_o
);

  localparam int unsigned DEPTH    = `ID_TABLE_DEPTH;
  // address bit that picks the 64-bit lane of a bus word
  localparam int unsigned LANE_BIT = $clog2(`HOST_DW / 8);

  logic [DEPTH-1:0]    busy_q;
  logic [`HOST_IW-1:0] id_q [DEPTH];
  logic [DEPTH-1:0]    lane_q;

  pulp_soc_pkg::slot_t free_slot;
  pulp_soc_pkg::slot_t resp_slot;
  logic                any_free;
  logic                req_xfer;
  logic                resp_xfer;

  // scan downward so the lowest free slot is the last one written
  always_comb begin
    free_slot = '0;
    any_free  = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_slot = pulp_soc_pkg::slot_t'(i);
        any_free  = 1'b1;
      end
    end
  end

  // request path, same cycle
  always_comb begin
    bus_req_o.valid = host_req_i.valid & any_free;
    bus_req_o.op    = host_req_i.op;
    bus_req_o.slot  = free_slot;
    bus_req_o.addr  = host_req_i.addr;
    bus_req_o.wdata = {{(`BUS_DW - `HOST_DW){1'b0}}, host_req_i.wdata};
    bus_req_o.wstrb = {{(`BUS_DW / 8 - `HOST_DW / 8){1'b0}}, host_req_i.wstrb};
  end

  // stall when the table is full
  assign host_req_ready_o = host_req_i.valid & any_free & bus_req_ready_i;
  assign req_xfer         = host_req_i.valid & host_req_ready_o;

  // response path, restore the host ID and pick the lane
  assign resp_slot        = bus_resp_i.slot;
  assign bus_resp_ready_o = host_resp_ready_i;
  assign resp_xfer        = bus_resp_i.valid & host_resp_ready_i;

  always_comb begin
    host_resp_o.valid  = bus_resp_i.valid;
    host_resp_o.id     = id_q[resp_slot];
    host_resp_o.status = bus_resp_i.status;
    if (lane_q[resp_slot]) begin
      host_resp_o.rdata = bus_resp_i.rdata[`BUS_DW-1 -: `HOST_DW];
    end else begin
      host_resp_o.rdata = bus_resp_i.rdata[`HOST_DW-1:0];
    end
  end

  // a freed slot is always busy, so it never collides with the allocated one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= '0;
    end else begin
      if (resp_xfer) begin
        busy_q[resp_slot] <= 1'b0;
      end
      if (req_xfer) begin
        busy_q[free_slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      id_q[free_slot]   <= host_req_i.id;
      lane_q[free_slot] <= host_req_i.addr[LANE_BIT];
    end
  end

  // whatever answers downstream must name a slot handed out here
  a_resp_slot_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_resp_i.valid |-> busy_q[bus_resp_i.slot])
    else $error("response for idle slot %0d", bus_resp_i.slot);

endmodule

// File: src/dw_upsizer.sv
`include "pulp_soc_cfg.svh"

module dw_upsizer (
  input  pulp_soc_pkg::bus_req_t  narrow_req_i,
  output logic                    narrow_req_ready_o,
  output pulp_soc_pkg::bus_resp_t narrow_resp_o,
  input  logic                    narrow_resp_ready_i,

  output pulp_soc_pkg::bus_req_t  wide_req_o,
  input  logic                    wide_req_ready_i,
  input  pulp_soc_pkg::bus_resp_t wide_resp_i,
  output logic                    wide_resp_ready_o
);

  localparam int unsigned NSTRB    = `HOST_DW / 8;
  localparam int unsigned LANE_BIT = $clog2(NSTRB);

  logic               lane;
  logic [`HOST_DW-1:0] narrow_data;
  logic [NSTRB-1:0]   narrow_strb;

  // only the low half of the narrow word carries data
  assign narrow_data = narrow_req_i.wdata[`HOST_DW-1:0];
  assign narrow_strb = narrow_req_i.wstrb[NSTRB-1:0];
  assign lane        = narrow_req_i.addr[LANE_BIT];

  always_comb begin
    wide_req_o.valid = narrow_req_i.valid;
    wide_req_o.op    = narrow_req_i.op;
    wide_req_o.slot  = narrow_req_i.slot;
    wide_req_o.addr  = narrow_req_i.addr;
    // same data in both lanes, strobes decide which one lands
    wide_req_o.wdata = {2{narrow_data}};
    if (lane) begin
      wide_req_o.wstrb = {narrow_strb, {NSTRB{1'b0}}};
    end else begin
      wide_req_o.wstrb = {{NSTRB{1'b0}}, narrow_strb};
    end
  end

  assign narrow_req_ready_o = wide_req_ready_i;

  // full word goes back, the remapper knows the lane per slot
  always_comb begin
    narrow_resp_o.valid  = wide_resp_i.valid;
    narrow_resp_o.slot   = wide_resp_i.slot;
    narrow_resp_o.rdata  = wide_resp_i.rdata;
    narrow_resp_o.status = wide_resp_i.status;
  end

  assign wide_resp_ready_o = narrow_resp_ready_i;

endmodule

// File: src/soc_bus.sv
`include "pulp_soc_cfg.svh"

module soc_bus (
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  pulp_soc_pkg::bus_req_t  slv_req_i,
  output logic                    slv_req_ready_o,
  output pulp_soc_pkg::bus_resp_t slv_resp_o,
  input  logic                    slv_resp_ready_i,

  output pulp_soc_pkg::bus_req_t  l2_req_o        [`L2_N_PORTS],
  input  logic [`L2_N_PORTS-1:0]  l2_req_ready_i,
  input  pulp_soc_pkg::bus_resp_t l2_resp_i       [`L2_N_PORTS],
  output logic [`L2_N_PORTS-1:0]  l2_resp_ready_o
);

  localparam int unsigned N_PORTS  = `L2_N_PORTS;
  localparam int unsigned BANK_W   = $clog2(N_PORTS);
  localparam int unsigned BANK_LSB = $clog2(`BUS_DW / 8);
  // banks are targets 0..N_PORTS-1, the error slave comes after them
  localparam int unsigned TGT_W    = $clog2(N_PORTS + 1);
  localparam int unsigned DEPTH    = `ORDER_DEPTH;
  localparam int unsigned PTR_W    = $clog2(DEPTH);

  localparam logic [TGT_W-1:0]   TGT_ERR = TGT_W'(N_PORTS);
  localparam logic [`AXI_AW-1:0] L2_BASE = `L2_BASE_ADDR;
  localparam logic [`AXI_AW-1:0] L2_END  = `L2_BASE_ADDR + `L2_SIZE;
  localparam logic [PTR_W:0]     FULL    = (PTR_W + 1)'(DEPTH);

  logic              in_l2;
  logic [BANK_W-1:0] bank;
  logic [TGT_W-1:0]  req_tgt;
  logic [TGT_W-1:0]  head;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;
  logic              err_ready;
  logic              err_xfer;

  logic [TGT_W-1:0]    order_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [PTR_W:0]      count_q;
  logic                err_valid_q;
  pulp_soc_pkg::slot_t err_slot_q;

  // address decode
  assign in_l2   = (slv_req_i.addr >= L2_BASE) && (slv_req_i.addr < L2_END);
  assign bank    = slv_req_i.addr[BANK_LSB +: BANK_W];
  assign req_tgt = in_l2 ? TGT_W'(bank) : TGT_ERR;

  assign full  = (count_q == FULL);
  assign empty = (count_q == '0);
  assign head  = order_q[rd_ptr_q];

  assign err_xfer  = !empty && (head == TGT_ERR) && err_valid_q && slv_resp_ready_i;
  assign err_ready = !err_valid_q || err_xfer;

  assign slv_req_ready_o = !full && (in_l2 ? l2_req_ready_i[bank] : err_ready);
  assign push            = slv_req_i.valid && slv_req_ready_o;
  assign pop             = slv_resp_o.valid && slv_resp_ready_i;

  for (genvar i = 0; i < N_PORTS; i++) begin : gen_l2_ports
    // a bank may only take the access once its slot in the queue is free
    always_comb begin
      l2_req_o[i]       = slv_req_i;
      l2_req_o[i].valid = slv_req_i.valid && in_l2 && !full && (bank == BANK_W'(i));
    end
    assign l2_resp_ready_o[i] = !empty && (head == TGT_W'(i)) && slv_resp_ready_i;
  end

  // only the head target may answer
  always_comb begin
    slv_resp_o = '0;
    if (!empty) begin
      if (head == TGT_ERR) begin
        slv_resp_o.valid  = err_valid_q;
        slv_resp_o.slot   = err_slot_q;
        slv_resp_o.status = pulp_soc_pkg::RESP_DECERR;
      end else begin
        slv_resp_o = l2_resp_i[head[BANK_W-1:0]];
      end
    end
  end

  // decode error slave, one entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_valid_q <= 1'b0;
    end else if (push && !in_l2) begin
      err_valid_q <= 1'b1;
    end else if (err_xfer) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !in_l2) begin
      err_slot_q <= slv_req_i.slot;
    end
  end

  // order queue
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= req_tgt;
    end
  end

  // occupancy must agree with the pointer distance
  a_order_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= FULL && count_q[PTR_W-1:0] == PTR_W'(wr_ptr_q - rd_ptr_q))
    else $error("order queue overflow, count %0d", count_q);

endmodule

// File: src/l2_mem.sv
`include "pulp_soc_cfg.svh"

module l2_mem (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  pulp_soc_pkg::bus_req_t  req_i,
  output logic                    req_ready_o,
  output pulp_soc_pkg::bus_resp_t resp_o,
  input  logic                    resp_ready_i
);

  localparam int unsigned N_BYTES = `L2_SIZE / `L2_N_PORTS;
  localparam int unsigned N_STRB  = `BUS_DW / 8;
  localparam int unsigned N_WORDS = N_BYTES / N_STRB;
  localparam int unsigned IDX_W   = $clog2(N_WORDS);
  // word index starts above the byte offset and the bank select
  localparam int unsigned IDX_LSB = $clog2(N_STRB) + $clog2(`L2_N_PORTS);

  logic [`BUS_DW-1:0] mem_q [N_WORDS];
  logic [IDX_W-1:0]   idx;
  logic               accept;
  logic               is_write;

  logic                resp_valid_q;
  pulp_soc_pkg::slot_t resp_slot_q;
  logic [`BUS_DW-1:0]  resp_rdata_q;

  assign idx      = req_i.addr[IDX_LSB +: IDX_W];
  assign is_write = (req_i.op == pulp_soc_pkg::OP_WRITE);

  // take a new access when the response slot frees up this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_i.valid && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept && is_write) begin
      for (int b = 0; b < N_STRB; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_slot_q  <= req_i.slot;
      resp_rdata_q <= is_write ? '0 : mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_comb begin
    resp_o.valid  = resp_valid_q;
    resp_o.slot   = resp_slot_q;
    resp_o.rdata  = resp_rdata_q;
    resp_o.status = pulp_soc_pkg::RESP_OKAY;
  end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_o.valid && !resp_ready_i |=> resp_o.valid && $stable(resp_o))
    else $error("held response changed before transfer");

endmodule

// File: src/pulp_soc.sv
`include "pulp_soc_cfg.svh"

module pulp_soc (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  pulp_soc_pkg::host_req_t  host_req_i,
  output logic                     host_req_ready_o,
  output pulp_soc_pkg::host_resp_t host_resp_o,
  input  logic                     host_resp_ready_i
);

  // remapper to upsizer, 64-bit payload
  pulp_soc_pkg::bus_req_t  narrow_req;
  logic                    narrow_req_ready;
  pulp_soc_pkg::bus_resp_t narrow_resp;
  logic                    narrow_resp_ready;

  // upsizer to bus, 128-bit payload
  pulp_soc_pkg::bus_req_t  wide_req;
  logic                    wide_req_ready;
  pulp_soc_pkg::bus_resp_t wide_resp;
  logic                    wide_resp_ready;

  // bus to banks
  pulp_soc_pkg::bus_req_t  l2_req        [`L2_N_PORTS];
  logic [`L2_N_PORTS-1:0]  l2_req_ready;
  pulp_soc_pkg::bus_resp_t l2_resp       [`L2_N_PORTS];
  logic [`L2_N_PORTS-1:0]  l2_resp_ready;

  host_id_remap i_host_id_remap (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .host_req_i        (host_req_i),
    .host_req_ready_o  (host_req_ready_o),
    .host_resp_o       (host_resp_o),
    .host_resp_ready_i (host_resp_ready_i),
    .bus_req_o         (narrow_req),
    .bus_req_ready_i   (narrow_req_ready),
    .bus_resp_i        (narrow_resp),
    .bus_resp_ready_o  (narrow_resp_ready)
  );

  dw_upsizer i_dw_upsizer (
    .narrow_req_i        (narrow_req),
    .narrow_req_ready_o  (narrow_req_ready),
    .narrow_resp_o       (narrow_resp),
    .narrow_resp_ready_i (narrow_resp_ready),
    .wide_req_o          (wide_req),
    .wide_req_ready_i    (wide_req_ready),
    .wide_resp_i         (wide_resp),
    .wide_resp_ready_o   (wide_resp_ready)
  );

  soc_bus i_soc_bus (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .slv_req_i        (wide_req),
    .slv_req_ready_o  (wide_req_ready),
    .slv_resp_o       (wide_resp),
    .slv_resp_ready_i (wide_resp_ready),
    .l2_req_o         (l2_req),
    .l2_req_ready_i   (l2_req_ready),
    .l2_resp_i        (l2_resp),
    .l2_resp_ready_o  (l2_resp_ready)
  );

  for (genvar i = 0; i < `L2_N_PORTS; i++) begin : gen_l2_ports
    l2_mem i_l2_mem (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (l2_req[i]),
      .req_ready_o  (l2_req_ready[i]),
      .resp_o       (l2_resp[i]),
      .resp_ready_i (l2_resp_ready[i])
    );
  end

endmodule

// File: tests/tb_pulp_soc.sv
`include "pulp_soc_cfg.svh"

module tb_pulp_soc;

  localparam int unsigned N_TXN      = 400;
  localparam int unsigned MAX_CYCLES = N_TXN * 10;
  localparam logic [31:0] L2_END     = `L2_BASE_ADDR + `L2_SIZE;

  // rdata is compared only where mask is set
  typedef struct packed {
    logic [`HOST_IW-1:0] id;
    logic [`HOST_DW-1:0] rdata;
    logic [`HOST_DW-1:0] mask;
    pulp_soc_pkg::resp_e status;
  } exp_resp_t;

  logic                     clk_i;
  logic                     reset_i;
  pulp_soc_pkg::host_req_t  host_req_i;
  logic                     host_req_ready_o;
  pulp_soc_pkg::host_resp_t host_resp_o;
  logic                     host_resp_ready_i;

  logic [31:0]             lfsr_state;
  logic [7:0]              ref_mem [logic [31:0]];
  exp_resp_t               exp_q [$];
  exp_resp_t               head;
  logic                    head_valid;
  int unsigned             n_out;
  int unsigned             n_sent;
  int unsigned             n_issued;
  int unsigned             cycle_cnt;
  logic                    req_fire_q;
  logic                    resp_fire_q;
  pulp_soc_pkg::host_req_t cap_req;
  logic                    resp_xfer;

  pulp_soc u_pulp_soc (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .host_req_i        (host_req_i),
    .host_req_ready_o  (host_req_ready_o),
    .host_resp_o       (host_resp_o),
    .host_resp_ready_i (host_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // galois form, lsb is the bit taken
  function automatic logic [63:0] draw_bits(input int unsigned n);
    logic [63:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'hD000_0001;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return val;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic make_request();
    pulp_soc_pkg::host_req_t req;
    logic [31:0]             offset;
    logic [2:0]              region;
    req       = host_req_i;
    offset    = 32'(draw_bits(6)) << 3;
    region    = 3'(draw_bits(3));
    req.valid = 1'b1;
    req.op    = draw_bits(1) ? pulp_soc_pkg::OP_WRITE : pulp_soc_pkg::OP_READ;
    // outside addresses alias the same word index as the L2 ones
    if (region == 3'd0) begin
      req.addr = draw_bits(1) ? L2_END + offset : `L2_BASE_ADDR - `L2_SIZE + offset;
    end else begin
      req.addr = `L2_BASE_ADDR + offset;
    end
    req.wdata = draw_bits(64);
    req.wstrb = draw_bits(1) ? 8'hFF : 8'(draw_bits(8));
    // keep the last id now and then
    if (draw_bits(2) != 0) begin
      req.id = 8'(draw_bits(8));
    end
    host_req_i = req;
    n_issued++;
  endtask

  initial begin
    int unsigned stall;
    lfsr_state        = 32'h8626_3174;
    reset_i           = 1'b1;
    host_req_i        = '0;
    host_resp_ready_i = 1'b0;
    stall             = 0;
    repeat (2) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    while (n_sent < N_TXN || n_out != 0) begin
      // a request holds until it transfers
      if (!host_req_i.valid || req_fire_q) begin
        if (n_issued < N_TXN && draw_bits(3) != 0) begin
          make_request();
        end else begin
          host_req_i.valid = 1'b0;
        end
      end
      // long stall so the id table fills up
      if (stall == 0 && req_fire_q && n_sent % 80 == 40) begin
        stall = 12;
      end
      if (stall != 0) begin
        stall--;
        host_resp_ready_i = 1'b0;
      end else begin
        host_resp_ready_i = (draw_bits(2) != 0);
      end
      @(posedge clk_i);
      #5;
    end
    // idle cycles to catch stray responses
    host_req_i.valid  = 1'b0;
    host_resp_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    $display("Test passed");
    $finish;
  end

  // handshakes seen mid-cycle, applied on the next rising edge
  always @(negedge clk_i) begin
    req_fire_q  <= host_req_i.valid && host_req_ready_o;
    resp_fire_q <= host_resp_o.valid && host_resp_ready_i;
    cap_req     <= host_req_i;
  end

  // reference memory and queue of expected responses
  always @(posedge clk_i) begin
    exp_resp_t   exp;
    logic [31:0] key;
    if (reset_i) begin
      exp_q.delete();
    end else begin
      if (resp_fire_q && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_fire_q) begin
        exp.id     = cap_req.id;
        exp.rdata  = '0;
        exp.mask   = '0;
        exp.status = pulp_soc_pkg::RESP_OKAY;
        if (cap_req.addr < `L2_BASE_ADDR || cap_req.addr >= L2_END) begin
          exp.status = pulp_soc_pkg::RESP_DECERR;
          exp.mask   = '1;
        end else begin
          for (int b = 0; b < 8; b++) begin
            key = {cap_req.addr[31:3], 3'(b)};
            if (cap_req.op == pulp_soc_pkg::OP_WRITE) begin
              if (cap_req.wstrb[b]) begin
                ref_mem[key] = cap_req.wdata[b*8 +: 8];
              end
            end else if (ref_mem.exists(key)) begin
              exp.rdata[b*8 +: 8] = ref_mem[key];
              exp.mask[b*8 +: 8]  = 8'hFF;
            end
          end
        end
        exp_q.push_back(exp);
        n_sent++;
      end
    end
    n_out      = exp_q.size();
    head_valid = (n_out != 0);
    if (head_valid) begin
      head = exp_q[0];
    end else begin
      head = '0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  assign resp_xfer = host_resp_o.valid && host_resp_ready_i;

  a_reset_quiet: assert property (@(negedge clk_i)
    reset_i |-> !host_resp_o.valid && !host_req_ready_o)
    else begin
      $display("error, DUT outputs active during reset at time %0t", $time);
      abort_run();
    end

  a_resp_expected: assert property (@(negedge clk_i) disable iff (reset_i)
    resp_xfer |-> head_valid)
    else begin
      $display("error, response delivered with no request outstanding at time %0t", $time);
      abort_run();
    end

  a_resp_id: assert property (@(negedge clk_i) disable iff (reset_i)
    resp_xfer && head_valid |-> host_resp_o.id == head.id)
    else begin
      $display("** Error at %0t: response id %0h, expected %0h", $time,
               host_resp_o.id, head.id);
      abort_run();
    end

  a_resp_status: assert property (@(negedge clk_i) disable iff (reset_i)
    resp_xfer && head_valid |-> host_resp_o.status == head.status)
    else begin
      $display("** Error at %0t: response status %0d, expected %0d", $time,
               host_resp_o.status, head.status);
      abort_run();
    end

  a_resp_data: assert property (@(negedge clk_i) disable iff (reset_i)
    resp_xfer && head_valid |-> ((host_resp_o.rdata ^ head.rdata) & head.mask) == '0)
    else begin
      $display("** Error at %0t: read data %h, expected %h under mask %h", $time,
               host_resp_o.rdata, head.rdata, head.mask);
      abort_run();
    end

  // table full means no more requests
  a_table_limit: assert property (@(negedge clk_i) disable iff (reset_i)
    n_out >= `ID_TABLE_DEPTH |-> !host_req_ready_o)
    else begin
      $display("** Error at %0t: request ready with %0d accesses outstanding", $time, n_out);
      abort_run();
    end

endmodule

// File: pulp_soc.f
+incdir+src
src/pulp_soc_pkg.sv
src/host_id_remap.sv
src/dw_upsizer.sv
src/soc_bus.sv
src/l2_mem.sv
src/pulp_soc.sv
tests/tb_pulp_soc.sv

// File: Makefile
TOP := tb_pulp_soc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timing --top-module $(TOP) -f pulp_soc.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
